//--- display_pkg.sv
// --------------------------------------------------
// screen geometry and timing for 640x480 at 60 Hz
// import into any block that counts or reads pixels
// --------------------------------------------------

package display_pkg;

    localparam int CORDW = 10;                  // coordinate width in bits

    typedef logic [CORDW-1:0] coord_t;          // one screen coordinate

    // active area
    localparam int H_RES = 640;                 // visible pixels per line
    localparam int V_RES = 480;                 // visible lines per frame

    // horizontal timing in pixels
    localparam int H_FP   = 16;                 // front porch
    localparam int H_SYNC = 96;                 // sync pulse width
    localparam int H_BP   = 48;                 // back porch

    // vertical timing in lines
    localparam int V_FP   = 10;                 // front porch
    localparam int V_SYNC = 2;                  // sync pulse width
    localparam int V_BP   = 33;                 // back porch

    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;  // 800
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;  // 525

    // sync windows, both ends inclusive
    localparam int HS_START = H_RES + H_FP;                 // 656
    localparam int HS_END   = HS_START + H_SYNC - 1;        // 751
    localparam int VS_START = V_RES + V_FP;                 // 490
    localparam int VS_END   = VS_START + V_SYNC - 1;        // 491

    // beam state handed from the timing generator to every consumer
    typedef struct packed {
        coord_t sx;                             // pixel within line
        coord_t sy;                             // line within frame
        logic   hsync;                          // line level, active low
        logic   vsync;                          // line level, active low
        logic   de;                             // inside the active area
        logic   frame;                          // start of vertical blanking
    } timing_t;

endpackage

//--- paint_pkg.sv
// --------------------------------------------------
// colour type, palette and per-pixel object hits
// used by the square engines and the pixel painter
// --------------------------------------------------

package paint_pkg;

    // 4 bits per channel, as on a resistor DAC
    typedef struct packed {
        logic [3:0] r;                          // red
        logic [3:0] g;                          // green
        logic [3:0] b;                          // blue
    } rgb_t;

    // palette
    localparam rgb_t COLOUR_A     = '{r: 4'hF, g: 4'hF, b: 4'hF};  // white square
    localparam rgb_t COLOUR_B     = '{r: 4'hF, g: 4'h8, b: 4'h0};  // orange square
    localparam rgb_t COLOUR_BG    = '{r: 4'h1, g: 4'h3, b: 4'h7};  // blue background
    localparam rgb_t COLOUR_BLANK = '{r: 4'h0, g: 4'h0, b: 4'h0};  // blanking black

    // one flag per object on screen
    typedef struct packed {
        logic hit_a;                            // pixel inside square a
        logic hit_b;                            // pixel inside square b
    } hits_t;

endpackage

//--- display_timing.sv
// --------------------------------------------------
// pixel and line counters for 640x480 at 60 Hz
// drives coordinates, syncs, data enable, frame pulse
// --------------------------------------------------

module display_timing
    import display_pkg::*;
(
    input  logic    clk_pix,                    // pixel clock
    input  logic    rst,                        // sync reset, active high
    output timing_t tim                         // beam state for this pixel
);

    coord_t sx;                                 // current pixel
    coord_t sy;                                 // current line
    coord_t sx_next;                            // pixel on the next cycle
    coord_t sy_next;                            // line on the next cycle
    logic   hsync;
    logic   vsync;
    logic   de;

    // next beam position, wraps at end of line and end of frame
    always_comb begin
        if (int'(sx) == H_TOTAL - 1) begin
            sx_next = '0;                       // back to start of line
            if (int'(sy) == V_TOTAL - 1) begin
                sy_next = '0;                   // back to top of frame
            end else begin
                sy_next = sy + 1'b1;            // next line
            end
        end else begin
            sx_next = sx + 1'b1;
            sy_next = sy;
        end
    end

    // syncs and de come from the next position so they line up with sx, sy
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx    <= '0;
            sy    <= '0;
            hsync <= 1'b1;                      // inactive
            vsync <= 1'b1;                      // inactive
            de    <= 1'b1;                      // (0,0) is visible
        end else begin
            sx    <= sx_next;
            sy    <= sy_next;
            hsync <= !(int'(sx_next) >= HS_START && int'(sx_next) <= HS_END);
            vsync <= !(int'(sy_next) >= VS_START && int'(sy_next) <= VS_END);
            de    <= (int'(sx_next) < H_RES) && (int'(sy_next) < V_RES);
        end
    end

    always_comb begin
        tim.sx    = sx;
        tim.sy    = sy;
        tim.hsync = hsync;
        tim.vsync = vsync;
        tim.de    = de;
        tim.frame = (int'(sy) == V_RES) && (sx == '0);  // first blanking line
    end

endmodule

//--- bounce_square.sv
// --------------------------------------------------
// one bouncing square, moved once per frame
// reports whether the current pixel lies inside it
// --------------------------------------------------

module bounce_square
    import display_pkg::*;
#(
    parameter int SIZE  = 64,                   // side length in pixels
    parameter int SPEED = 1,                    // pixels per frame
    parameter int X0    = 0,                    // start column
    parameter int Y0    = 0                     // start line
) (
    input  logic    clk_pix,                    // pixel clock
    input  logic    rst,                        // sync reset, active high
    input  timing_t tim,                        // beam state
    output logic    hit                         // pixel inside square
);

    // position and heading along one axis
    typedef struct packed {
        coord_t pos;                            // top or left edge
        logic   back;                           // 0 is right/down
    } axis_t;

    axis_t ax;                                  // horizontal axis
    axis_t ay;                                  // vertical axis

    // one frame step along an axis of length res
    function automatic axis_t axis_step(axis_t cur, int res);
        axis_t nxt;
        nxt = cur;
        if (!cur.back) begin                    // moving right or down
            if (int'(cur.pos) + SIZE + SPEED >= res - 1) begin
                nxt.pos  = coord_t'(res - SIZE - 1);  // clamp at far edge
                nxt.back = 1'b1;                // turn around
            end else begin
                nxt.pos = cur.pos + coord_t'(SPEED);
            end
        end else begin                          // moving left or up
            if (int'(cur.pos) < SPEED) begin
                nxt.pos  = '0;                  // clamp at near edge
                nxt.back = 1'b0;
            end else begin
                nxt.pos = cur.pos - coord_t'(SPEED);
            end
        end
        return nxt;
    endfunction

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            ax <= '{pos: coord_t'(X0), back: 1'b0};
            ay <= '{pos: coord_t'(Y0), back: 1'b0};
        end else if (tim.frame) begin           // once per frame, in blanking
            ax <= axis_step(ax, H_RES);
            ay <= axis_step(ay, V_RES);
        end
    end

    // inside test, left and top edges inclusive
    always_comb begin
        hit = (int'(tim.sx) >= int'(ax.pos))
            && (int'(tim.sx) < int'(ax.pos) + SIZE)
            && (int'(tim.sy) >= int'(ay.pos))
            && (int'(tim.sy) < int'(ay.pos) + SIZE);
    end

endmodule

//--- pixel_painter.sv
// --------------------------------------------------
// picks the colour for each pixel by object priority
// and registers it with the syncs for the VGA port
// --------------------------------------------------

module pixel_painter
    import display_pkg::*, paint_pkg::*;
(
    input  logic    clk_pix,                    // pixel clock
    input  logic    rst,                        // sync reset, active high
    input  timing_t tim,                        // beam state
    input  hits_t   hits,                       // object flags for this pixel
    output logic    vga_hsync,                  // registered hsync
    output logic    vga_vsync,                  // registered vsync
    output rgb_t    vga_rgb                     // registered colour
);

    rgb_t paint;                                // colour before blanking
    rgb_t colour;                               // colour after blanking

    // square a sits in front of square b
    always_comb begin
        if (hits.hit_a) begin
            paint = COLOUR_A;
        end else if (hits.hit_b) begin
            paint = COLOUR_B;
        end else begin
            paint = COLOUR_BG;
        end
    end

    always_comb begin
        colour = tim.de ? paint : COLOUR_BLANK; // black outside active area
    end

    // colour and syncs share one stage, so they stay aligned
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_rgb   <= COLOUR_BLANK;
        end else begin
            vga_hsync <= tim.hsync;
            vga_vsync <= tim.vsync;
            vga_rgb   <= colour;
        end
    end

endmodule

//--- bounce_top.sv
// --------------------------------------------------
// two bouncing squares on a 640x480 VGA screen
// timing generator, two square engines and painter
// --------------------------------------------------

module bounce_top
    import display_pkg::*, paint_pkg::*;
(
    input  logic clk_pix,                       // 25.175 MHz pixel clock
    input  logic rst,                           // sync reset, active high
    output logic vga_hsync,                     // VGA horizontal sync
    output logic vga_vsync,                     // VGA vertical sync
    output rgb_t vga_rgb                        // VGA colour
);

    timing_t tim;                               // beam state, shared
    hits_t   hits;                              // one flag per square

    display_timing display_inst (
        .clk_pix (clk_pix),
        .rst     (rst),
        .tim     (tim)
    );

    // big slow square, front
    bounce_square #(.SIZE(200), .SPEED(2), .X0(0), .Y0(0)) square_a (
        .clk_pix (clk_pix),
        .rst     (rst),
        .tim     (tim),
        .hit     (hits.hit_a)
    );

    // small fast square, behind
    bounce_square #(.SIZE(64), .SPEED(5), .X0(400), .Y0(300)) square_b (
        .clk_pix (clk_pix),
        .rst     (rst),
        .tim     (tim),
        .hit     (hits.hit_b)
    );

    pixel_painter painter_inst (
        .clk_pix   (clk_pix),
        .rst       (rst),
        .tim       (tim),
        .hits      (hits),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_rgb   (vga_rgb)
    );

endmodule

//--- bounce_checker.sv
// --------------------------------------------------
// watches the VGA port of the bounce DUT and checks
// every pixel and sync level against a screen model
// --------------------------------------------------

module bounce_checker
    import display_pkg::*, paint_pkg::*;
(
    input  logic clk_pix,                       // pixel clock
    input  logic rst,                           // same reset as the DUT
    input  logic vga_hsync,                     // DUT outputs
    input  logic vga_vsync,
    input  rgb_t vga_rgb,
    output int   sync_errs,                     // sync levels and line timing
    output int   colour_errs,                   // pixel colour
    output int   misc_errs,                     // model, timeouts, coverage
    output int   frames_done,                   // complete frames modelled
    output int   vsync_count                    // vsync pulses seen at the port
);

    // square settings mirrored from bounce_top
    localparam int A_SIZE  = 200;
    localparam int A_SPEED = 2;
    localparam int A_X0    = 0;
    localparam int A_Y0    = 0;
    localparam int B_SIZE  = 64;
    localparam int B_SPEED = 5;
    localparam int B_X0    = 400;
    localparam int B_Y0    = 300;

    localparam logic [11:0] WHITE  = 12'hFFF;
    localparam logic [11:0] ORANGE = 12'hF80;
    localparam logic [11:0] BLUE   = 12'h137;
    localparam logic [11:0] BLACK  = 12'h000;

    localparam int FRAME_CYCLES  = H_TOTAL * V_TOTAL;
    localparam int VSYNC_TIMEOUT = 2 * FRAME_CYCLES;    // reset plus a whole frame
    localparam int EDGE_X        = 575;                 // b clamps here at the right
    localparam int MOTION_FRAMES = 20;                  // no bounce before this
    localparam int PRINT_LIMIT   = 20;

    typedef struct packed {
        int   pos;                              // top or left edge
        logic back;                             // 0 is right/down
    } axis_m_t;

    typedef struct packed {
        logic [11:0] rgb;
        logic        hsync;
        logic        vsync;
    } pixel_exp_t;

    int         csx;                            // model beam position
    int         csy;
    axis_m_t    ax_m;                           // model squares
    axis_m_t    ay_m;
    axis_m_t    bx_m;
    axis_m_t    by_m;
    int         steps;                          // frame moves so far
    int         cyc = 0;
    pixel_exp_t pend;                           // expected on the next edge
    string      pend_name;
    int         pend_sx;
    int         pend_sy;
    logic       prev_hs;
    logic       prev_vs;
    int         last_hs_fall;
    int         last_vs_fall;
    int         n_sync = 0;
    int         n_colour = 0;
    int         n_misc = 0;
    int         n_model = 0;                    // model self checks
    int         n_timeout = 0;
    int         n_vsync = 0;
    int         n_printed = 0;
    int         n_white = 0;                    // colours seen this frame
    int         n_orange = 0;
    int         n_blue = 0;

    assign sync_errs   = n_sync;
    assign colour_errs = n_colour;
    assign misc_errs   = n_misc + n_model + n_timeout;
    assign vsync_count = n_vsync;

    function automatic bit in_square(int sx, int sy, int x, int y, int size);
        return (sx >= x) && (sx < x + size) && (sy >= y) && (sy < y + size);
    endfunction

    // one frame step along one axis by the edge rule
    function automatic axis_m_t move_axis(axis_m_t cur, int size, int speed, int res);
        axis_m_t nxt;
        nxt = cur;
        if (!cur.back) begin
            if (cur.pos + size + speed >= res - 1) begin
                nxt.pos  = res - size - 1;      // stop at far edge
                nxt.back = 1'b1;
            end else begin
                nxt.pos = cur.pos + speed;
            end
        end else if (cur.pos < speed) begin
            nxt.pos  = 0;                       // stop at near edge
            nxt.back = 1'b0;
        end else begin
            nxt.pos = cur.pos - speed;
        end
        return nxt;
    endfunction

    // reference colour and sync levels for one beam position
    function automatic pixel_exp_t expected_pixel(int sx, int sy, int ax, int ay,
                                                  int bx, int by);
        pixel_exp_t e;
        e.hsync = !(sx >= H_RES + H_FP && sx < H_RES + H_FP + H_SYNC);
        e.vsync = !(sy >= V_RES + V_FP && sy < V_RES + V_FP + V_SYNC);
        if (sx >= H_RES || sy >= V_RES) begin
            e.rgb = BLACK;                      // blanking
        end else if (in_square(sx, sy, ax, ay, A_SIZE)) begin
            e.rgb = WHITE;                      // a wins
        end else if (in_square(sx, sy, bx, by, B_SIZE)) begin
            e.rgb = ORANGE;
        end else begin
            e.rgb = BLUE;
        end
        return e;
    endfunction

    function automatic string pixel_test(int sx, int sy, int ax, int ay, int bx, int by);
        bit in_a;
        bit in_b;
        in_a = in_square(sx, sy, ax, ay, A_SIZE);
        in_b = in_square(sx, sy, bx, by, B_SIZE);
        if (sx >= H_RES || sy >= V_RES) return "blanking";
        if (in_a && in_b) return "priority";
        if (in_a || in_b) return "motion";
        return "background";
    endfunction

    task automatic show_error(string name, int exp, int act);
        if (n_printed < PRINT_LIMIT) begin
            $display("Error %s: expected %0h, actual %0h at pixel (%0d, %0d)",
                     name, exp, act, pend_sx, pend_sy);
        end else if (n_printed == PRINT_LIMIT) begin
            $display("further mismatches are counted but not printed");
        end
        n_printed++;
    endtask

    task automatic compare_outputs();
        string hs_name;
        string vs_name;
        if (pend_name == "reset") begin
            hs_name = pend_name;
            vs_name = pend_name;
        end else begin
            hs_name = "hsync";
            vs_name = "vsync";
        end
        if (vga_hsync !== pend.hsync) begin
            n_sync++;
            show_error(hs_name, int'(pend.hsync), int'(vga_hsync));
        end
        if (vga_vsync !== pend.vsync) begin
            n_sync++;
            show_error(vs_name, int'(pend.vsync), int'(vga_vsync));
        end
        if (vga_rgb !== pend.rgb) begin
            n_colour++;
            show_error(pend_name, int'(pend.rgb), int'(vga_rgb));
        end
        if (vga_rgb === WHITE) n_white++;
        if (vga_rgb === ORANGE) n_orange++;
        if (vga_rgb === BLUE) n_blue++;
    endtask

    // falling edges at the port give line and frame length
    task automatic track_sync_edges();
        if (prev_hs === 1'b1 && vga_hsync === 1'b0) begin
            if (last_hs_fall >= 0 && cyc - last_hs_fall != H_TOTAL) begin
                n_sync++;
                show_error("line_length", H_TOTAL, cyc - last_hs_fall);
            end
            last_hs_fall = cyc;
        end
        if (prev_vs === 1'b1 && vga_vsync === 1'b0) begin
            n_vsync++;
            if (last_vs_fall >= 0 && cyc - last_vs_fall != FRAME_CYCLES) begin
                n_sync++;
                show_error("frame_length", FRAME_CYCLES, cyc - last_vs_fall);
            end
            last_vs_fall = cyc;
        end
        prev_hs = vga_hsync;
        prev_vs = vga_vsync;
    endtask

    task automatic advance_model();
        if (csy == V_RES && csx == 0) begin     // frame pulse moves the squares
            ax_m = move_axis(ax_m, A_SIZE, A_SPEED, H_RES);
            ay_m = move_axis(ay_m, A_SIZE, A_SPEED, V_RES);
            bx_m = move_axis(bx_m, B_SIZE, B_SPEED, H_RES);
            by_m = move_axis(by_m, B_SIZE, B_SPEED, V_RES);
            steps++;
            if (steps <= MOTION_FRAMES && (bx_m.pos != B_X0 + B_SPEED * steps
                    || by_m.pos != B_Y0 + B_SPEED * steps
                    || ax_m.pos != A_X0 + A_SPEED * steps
                    || ay_m.pos != A_Y0 + A_SPEED * steps)) begin
                n_model++;
                $display("Error motion: expected b (%0d, %0d), actual (%0d, %0d) in frame %0d",
                         B_X0 + B_SPEED * steps, B_Y0 + B_SPEED * steps,
                         bx_m.pos, by_m.pos, steps);
            end
        end
        if (csx == H_TOTAL - 1) begin
            csx = 0;
            if (csy == V_TOTAL - 1) begin       // frame complete
                csy = 0;
                frames_done <= frames_done + 1;
                if (n_white == 0 || n_orange == 0 || n_blue == 0) begin
                    n_misc++;
                    $display("a colour was missing from frame %0d: white %0d, orange %0d, blue %0d",
                             steps, n_white, n_orange, n_blue);
                end
                n_white = 0;
                n_orange = 0;
                n_blue = 0;
            end else begin
                csy++;
            end
        end else begin
            csx++;
        end
    endtask

    // compare what the DUT registered last cycle, then predict this one
    always @(posedge clk_pix) begin
        cyc++;
        if (rst) begin
            csx = 0;
            csy = 0;
            ax_m = '{pos: A_X0, back: 1'b0};
            ay_m = '{pos: A_Y0, back: 1'b0};
            bx_m = '{pos: B_X0, back: 1'b0};
            by_m = '{pos: B_Y0, back: 1'b0};
            steps = 0;
            pend = '{rgb: BLACK, hsync: 1'b1, vsync: 1'b1};  // reset levels
            pend_name = "reset";
            pend_sx = 0;
            pend_sy = 0;
            prev_hs = 1'b1;
            prev_vs = 1'b1;
            last_hs_fall = -1;
            last_vs_fall = -1;
            frames_done <= 0;
        end else begin
            compare_outputs();
            track_sync_edges();
            pend = expected_pixel(csx, csy, ax_m.pos, ay_m.pos, bx_m.pos, by_m.pos);
            pend_name = pixel_test(csx, csy, ax_m.pos, ay_m.pos, bx_m.pos, by_m.pos);
            pend_sx = csx;
            pend_sy = csy;
            advance_model();
        end
    end

    initial begin : first_vsync_wait
        int waited;
        waited = 0;
        while (vga_vsync !== 1'b0 && waited < VSYNC_TIMEOUT) begin
            @(posedge clk_pix);
            waited++;
        end
        if (vga_vsync !== 1'b0) begin
            n_timeout++;
            $display("timeout: vsync never arrived within %0d cycles", waited);
        end
    end

    // square b run to the right edge without simulating 35 frames
    initial begin : model_self_checks
        axis_m_t    b;
        pixel_exp_t p;
        int         n;
        n = 0;
        b = '{pos: B_X0, back: 1'b0};
        while (!b.back && n < 60) begin
            b = move_axis(b, B_SIZE, B_SPEED, H_RES);
            n++;
        end
        if (!b.back) begin
            n_model++;
            $display("square b never turned at the right edge in %0d frames", n);
        end else begin
            if (b.pos != EDGE_X) begin
                n_model++;
                $display("Error edge_bounce: expected %0d, actual %0d", EDGE_X, b.pos);
            end
            b = move_axis(b, B_SIZE, B_SPEED, H_RES);   // must now head left
            if (b.pos != EDGE_X - B_SPEED) begin
                n_model++;
                $display("Error edge_bounce: expected %0d, actual %0d",
                         EDGE_X - B_SPEED, b.pos);
            end
        end
        p = expected_pixel(100, 100, 50, 50, 80, 80);   // inside both squares
        if (p.rgb != WHITE) begin
            n_model++;
            $display("Error priority: expected %0h, actual %0h", WHITE, p.rgb);
        end
        p = expected_pixel(300, 300, 0, 0, 400, 300);   // active, outside both
        if (p.rgb != BLUE) begin
            n_model++;
            $display("Error priority: expected %0h, actual %0h", BLUE, p.rgb);
        end
    end

endmodule

//--- tb_bounce.sv
// --------------------------------------------------
// testbench for the bouncing squares VGA design
// runs five frames, checker compares every pixel
// --------------------------------------------------

module tb_bounce
    import display_pkg::*, paint_pkg::*;
();

    localparam int FRAMES     = 5;
    localparam int RUN_CYCLES = FRAMES * H_TOTAL * V_TOTAL;    // 2,100,000
    localparam int SLACK      = 2 * H_TOTAL;                   // margin on the run wait

    logic clk_pix;
    logic rst;
    logic vga_hsync;
    logic vga_vsync;
    rgb_t vga_rgb;

    int   sync_errs;                            // from the checker
    int   colour_errs;
    int   misc_errs;
    int   frames_done;
    int   vsync_count;
    int   cycles;
    int   total;
    bit   timed_out;

    initial begin : clock_gen
        clk_pix = 1'b0;
        forever #5 clk_pix = ~clk_pix;          // period 10
    end

    bounce_top dut (
        .clk_pix   (clk_pix),
        .rst       (rst),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_rgb   (vga_rgb)
    );

    bounce_checker chk (
        .clk_pix     (clk_pix),
        .rst         (rst),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync),
        .vga_rgb     (vga_rgb),
        .sync_errs   (sync_errs),
        .colour_errs (colour_errs),
        .misc_errs   (misc_errs),
        .frames_done (frames_done),
        .vsync_count (vsync_count)
    );

    initial begin : run
        int reset_cycles;
        rst = 1'b1;                             // held from time 0
        cycles = 0;
        timed_out = 1'b0;
        reset_cycles = 0;
        while (reset_cycles < 2) begin          // two reset edges
            @(posedge clk_pix);
            reset_cycles++;
        end
        rst <= 1'b0;

        // five full frames, bounded by cycle count
        while (frames_done < FRAMES && cycles < RUN_CYCLES + SLACK) begin
            @(posedge clk_pix);
            cycles++;
        end
        if (frames_done < FRAMES) begin
            timed_out = 1'b1;
            $display("timeout: only %0d of %0d frames finished after %0d cycles",
                     frames_done, FRAMES, cycles);
        end
        reset_cycles = 0;
        while (reset_cycles < 2) begin          // let the last compare land
            @(posedge clk_pix);
            reset_cycles++;
        end

        total = sync_errs + colour_errs + misc_errs;
        if (vsync_count != FRAMES) begin
            total++;
            $display("saw %0d vsync pulses at the port where %0d frames should give %0d",
                     vsync_count, FRAMES, FRAMES);
        end
        $display("run of %0d cycles, errors: sync %0d, colour %0d, other %0d, total %0d",
                 cycles, sync_errs, colour_errs, misc_errs, total);
        if (total == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- sources.f
display_pkg.sv
paint_pkg.sv
display_timing.sv
bounce_square.sv
pixel_painter.sv
bounce_top.sv
bounce_checker.sv
tb_bounce.sv

//--- Makefile
# Verilator build and run for the bouncing squares VGA design

TOP = tb_bounce

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f sources.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

lint:
	verilator --lint-only -Wall --top-module bounce_top \
		display_pkg.sv paint_pkg.sv display_timing.sv bounce_square.sv \
		pixel_painter.sv bounce_top.sv
	verilator --lint-only --timing --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir
